//--- Bender.yml
package:
  name: cornet

export_include_dirs:
  - include

sources:
  - design/cornet_pkg.sv
  - design/cornet_sequencer.sv
  - design/cornet_bus_unit.sv
  - design/cornet_execute.sv
  - design/cornet_cpu.sv
  - target: test
    files:
      - verif/cornet_cpu_checker.sv
      - verif/cornet_cpu_tb.sv

//--- design/cornet_bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cornet_bus_unit (
   input  wire                     clk,
   input  wire                     reset_n,
   input  wire                     fetch_req,
   input  wire cornet_pkg::addr_t  fetch_addr,
   input  wire cornet_pkg::rd_req_t rd_req,
   input  wire cornet_pkg::wr_req_t wr_req,
   input  wire cornet_pkg::data_t  rd_data,
   input  wire                     ready,
   output cornet_pkg::addr_t       addr,
   output cornet_pkg::data_t       wr_data,
   output logic                    wr_en,
   output logic                    bus_rd,
   output cornet_pkg::data_t       fetch_data,
   output logic                    fetch_valid,
   output cornet_pkg::rd_rsp_t     rd_rsp
);

   cornet_pkg::bus_state_e state;
   logic                   is_fetch;   // Pending read belongs to the opcode fetch.
   logic                   ack;
   cornet_pkg::data_t      byte_q;
   cornet_pkg::addr_t      word_q;

   assign fetch_data = byte_q;
   assign rd_rsp     = '{ack: ack, byte_data: byte_q, word_data: word_q};

   always_ff @(posedge clk)
   begin
      bus_rd      <= 1'b0;
      wr_en       <= 1'b0;
      fetch_valid <= 1'b0;
      ack         <= 1'b0;
      if (!reset_n)
         state <= cornet_pkg::bus_idle;
      else if (fetch_req)
      begin
         addr     <= fetch_addr;
         bus_rd   <= 1'b1;
         is_fetch <= 1'b1;
         state    <= cornet_pkg::bus_read_byte;
      end
      else if (rd_req.strobe)
      begin
         addr     <= rd_req.addr;
         bus_rd   <= 1'b1;
         is_fetch <= 1'b0;
         state    <= rd_req.word ? cornet_pkg::bus_read_word_low : cornet_pkg::bus_read_byte;
      end
      else if (wr_req.strobe)
      begin
         addr    <= wr_req.addr;
         wr_data <= wr_req.data;
         wr_en   <= 1'b1;
         state   <= cornet_pkg::bus_idle;
      end
      else if (ready && !bus_rd)   // Data is valid only after the request cycle.
      begin
         case (state)
            cornet_pkg::bus_read_byte:
            begin
               byte_q      <= rd_data;
               fetch_valid <= is_fetch;
               ack         <= !is_fetch;
               state       <= cornet_pkg::bus_idle;
            end
            cornet_pkg::bus_read_word_low:
            begin
               word_q[7:0] <= rd_data;
               addr        <= addr + 1'b1;
               bus_rd      <= 1'b1;
               state       <= cornet_pkg::bus_read_word_high;
            end
            cornet_pkg::bus_read_word_high:
            begin
               word_q[15:8] <= rd_data;
               ack          <= 1'b1;
               state        <= cornet_pkg::bus_idle;
            end
            default:
               state <= cornet_pkg::bus_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/cornet_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cornet_cpu (
   input  wire                    clk,
   input  wire                    reset_n,
   output cornet_pkg::addr_t      addr,
   input  wire cornet_pkg::data_t rd_data,
   output cornet_pkg::data_t      wr_data,
   output logic                   wr_en,
   output logic                   rd_req,
   input  wire                    ready
);

   logic                  fetch_req;
   cornet_pkg::addr_t     fetch_addr;
   cornet_pkg::data_t     fetch_data;
   logic                  fetch_valid;
   cornet_pkg::rd_req_t   seq_rd_req;     // Operand read from the sequencer.
   cornet_pkg::wr_req_t   exec_wr_req;
   cornet_pkg::rd_rsp_t   bus_rd_rsp;
   cornet_pkg::dec_op_t   dec_op;
   cornet_pkg::exec_rsp_t exec_rsp;

   cornet_sequencer cornet_sequencer_i (
      .clk         (clk),
      .reset_n     (reset_n),
      .fetch_data  (fetch_data),
      .fetch_valid (fetch_valid),
      .exec_rsp    (exec_rsp),
      .fetch_req   (fetch_req),
      .fetch_addr  (fetch_addr),
      .rd_req      (seq_rd_req),
      .dec_op      (dec_op)
   );

   cornet_bus_unit cornet_bus_unit_i (
      .clk         (clk),
      .reset_n     (reset_n),
      .fetch_req   (fetch_req),
      .fetch_addr  (fetch_addr),
      .rd_req      (seq_rd_req),
      .wr_req      (exec_wr_req),
      .rd_data     (rd_data),
      .ready       (ready),
      .addr        (addr),
      .wr_data     (wr_data),
      .wr_en       (wr_en),
      .bus_rd      (rd_req),
      .fetch_data  (fetch_data),
      .fetch_valid (fetch_valid),
      .rd_rsp      (bus_rd_rsp)
   );

   cornet_execute cornet_execute_i (
      .clk      (clk),
      .reset_n  (reset_n),
      .dec_op   (dec_op),
      .rd_rsp   (bus_rd_rsp),
      .wr_req   (exec_wr_req),
      .exec_rsp (exec_rsp)
   );

endmodule

`default_nettype wire

//--- design/cornet_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "cornet_cfg.svh"

module cornet_execute (
   input  wire                     clk,
   input  wire                     reset_n,
   input  wire cornet_pkg::dec_op_t dec_op,
   input  wire cornet_pkg::rd_rsp_t rd_rsp,
   output cornet_pkg::wr_req_t     wr_req,
   output cornet_pkg::exec_rsp_t   exec_rsp
);

   cornet_pkg::data_t      reg_a;
   cornet_pkg::data_t      reg_x;
   cornet_pkg::data_t      reg_y;
   logic                   flag_z;
   logic                   flag_c;
   cornet_pkg::exec_op_e   op_q;
   cornet_pkg::exec_op_e   cur_op;
   cornet_pkg::addr_t      pc_q;
   cornet_pkg::addr_t      cur_pc;
   logic [1:0]             len_q;
   logic [1:0]             cur_len;
   logic                   waiting;   // Instruction waits for its operand.
   logic                   fire;
   cornet_pkg::data_t      operand;
   logic [`CORNET_DATA_W:0] adc_sum;
   cornet_pkg::addr_t      seq_pc;
   cornet_pkg::addr_t      branch_pc;

   assign cur_op  = dec_op.start ? dec_op.op : op_q;
   assign cur_pc  = dec_op.start ? dec_op.pc : pc_q;
   assign cur_len = dec_op.start ? dec_op.len : len_q;
   assign fire    = (dec_op.start && dec_op.len == `CORNET_LEN_IMPLIED) ||
                    (rd_rsp.ack && waiting);

   assign operand = rd_rsp.byte_data;
   assign adc_sum = {1'b0, reg_a} + {1'b0, operand} + {{`CORNET_DATA_W{1'b0}}, flag_c};
   assign seq_pc  = cur_pc + cur_len;
   // Branch offsets count from the byte after the branch.
   assign branch_pc = cur_pc + `CORNET_LEN_IMM +
                      {{(`CORNET_ADDR_W-`CORNET_DATA_W){operand[`CORNET_DATA_W-1]}}, operand};

   always_ff @(posedge clk)
   begin
      wr_req.strobe <= 1'b0;
      exec_rsp.done <= 1'b0;
      if (!reset_n)
      begin
         waiting <= 1'b0;
         reg_a   <= '0;
         reg_x   <= '0;
         reg_y   <= '0;
         flag_z  <= 1'b0;
         flag_c  <= 1'b0;
      end
      else
      begin
         if (dec_op.start)
         begin
            op_q    <= dec_op.op;
            pc_q    <= dec_op.pc;
            len_q   <= dec_op.len;
            waiting <= (dec_op.len != `CORNET_LEN_IMPLIED);
         end
         else if (rd_rsp.ack)
            waiting <= 1'b0;

         if (fire)
         begin
            exec_rsp.done    <= 1'b1;
            exec_rsp.next_pc <= seq_pc;
            case (cur_op)
               cornet_pkg::op_reset:
               begin
                  reg_a            <= '0;
                  reg_x            <= '0;
                  reg_y            <= '0;
                  flag_z           <= 1'b0;
                  flag_c           <= 1'b0;
                  exec_rsp.next_pc <= rd_rsp.word_data;
               end
               cornet_pkg::op_lda: {reg_a, flag_z} <= {operand, operand == '0};
               cornet_pkg::op_ldx: {reg_x, flag_z} <= {operand, operand == '0};
               cornet_pkg::op_ldy: {reg_y, flag_z} <= {operand, operand == '0};
               cornet_pkg::op_adc:
               begin
                  {flag_c, reg_a} <= adc_sum;
                  flag_z          <= (adc_sum[`CORNET_DATA_W-1:0] == '0);
               end
               cornet_pkg::op_and: {reg_a, flag_z} <= {reg_a & operand, (reg_a & operand) == '0};
               cornet_pkg::op_ora: {reg_a, flag_z} <= {reg_a | operand, (reg_a | operand) == '0};
               cornet_pkg::op_cmp: flag_z <= (reg_a == operand);
               cornet_pkg::op_inx: {reg_x, flag_z} <= {reg_x + 1'b1, reg_x == '1};
               cornet_pkg::op_dex: {reg_x, flag_z} <= {reg_x - 1'b1, reg_x == 8'd1};
               cornet_pkg::op_tax: {reg_x, flag_z} <= {reg_a, reg_a == '0};
               cornet_pkg::op_txa: {reg_a, flag_z} <= {reg_x, reg_x == '0};
               cornet_pkg::op_clc: flag_c <= 1'b0;
               cornet_pkg::op_sec: flag_c <= 1'b1;
               cornet_pkg::op_sta:
               begin
                  wr_req.strobe <= 1'b1;
                  wr_req.addr   <= rd_rsp.word_data;
                  wr_req.data   <= reg_a;
               end
               cornet_pkg::op_jmp: exec_rsp.next_pc <= rd_rsp.word_data;
               cornet_pkg::op_beq:
                  if (flag_z)
                     exec_rsp.next_pc <= branch_pc;
               cornet_pkg::op_bne:
                  if (!flag_z)
                     exec_rsp.next_pc <= branch_pc;
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- design/cornet_pkg.sv
`default_nettype none
`include "cornet_cfg.svh"

package cornet_pkg;

   typedef logic [`CORNET_ADDR_W-1:0] addr_t;
   typedef logic [`CORNET_DATA_W-1:0] data_t;

   typedef enum logic [2:0] {
      seq_idle, seq_reset, seq_fetch, seq_load, seq_wait_exec
   } seq_state_e;

   typedef enum logic [1:0] {
      bus_idle, bus_read_byte, bus_read_word_low, bus_read_word_high
   } bus_state_e;

   typedef enum logic [4:0] {
      op_nop, op_reset, op_lda, op_ldx, op_ldy, op_adc, op_and, op_ora, op_cmp,
      op_inx, op_dex, op_tax, op_txa, op_clc, op_sec, op_sta, op_jmp, op_beq, op_bne
   } exec_op_e;

   typedef struct packed {logic strobe; logic word; addr_t addr;} rd_req_t;
   typedef struct packed {logic strobe; addr_t addr; data_t data;} wr_req_t;
   typedef struct packed {logic ack; data_t byte_data; addr_t word_data;} rd_rsp_t;

   typedef struct packed {
      logic       start;
      exec_op_e   op;
      logic [1:0] len;
      addr_t      pc;     // Address of the opcode byte.
   } dec_op_t;

   typedef struct packed {logic done; addr_t next_pc;} exec_rsp_t;

endpackage

`default_nettype wire

//--- design/cornet_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cornet_cfg.svh"

module cornet_sequencer (
   input  wire                       clk,
   input  wire                       reset_n,
   input  wire cornet_pkg::data_t    fetch_data,
   input  wire                       fetch_valid,
   input  wire cornet_pkg::exec_rsp_t exec_rsp,
   output logic                      fetch_req,
   output cornet_pkg::addr_t         fetch_addr,
   output cornet_pkg::rd_req_t       rd_req,
   output cornet_pkg::dec_op_t       dec_op
);

   cornet_pkg::seq_state_e state;
   cornet_pkg::addr_t      pc;
   cornet_pkg::exec_op_e   op_next;
   logic [1:0]             len_next;

   function automatic cornet_pkg::exec_op_e decode_op(input cornet_pkg::data_t opcode);
      case (opcode)
         8'hA9:   return cornet_pkg::op_lda;
         8'hA2:   return cornet_pkg::op_ldx;
         8'hA0:   return cornet_pkg::op_ldy;
         8'h69:   return cornet_pkg::op_adc;
         8'h29:   return cornet_pkg::op_and;
         8'h09:   return cornet_pkg::op_ora;
         8'hC9:   return cornet_pkg::op_cmp;
         8'hE8:   return cornet_pkg::op_inx;
         8'hCA:   return cornet_pkg::op_dex;
         8'hAA:   return cornet_pkg::op_tax;
         8'h8A:   return cornet_pkg::op_txa;
         8'h18:   return cornet_pkg::op_clc;
         8'h38:   return cornet_pkg::op_sec;
         8'h8D:   return cornet_pkg::op_sta;
         8'h4C:   return cornet_pkg::op_jmp;
         8'hF0:   return cornet_pkg::op_beq;
         8'hD0:   return cornet_pkg::op_bne;
         default: return cornet_pkg::op_nop;  // Unknown opcodes run as one-byte no-ops.
      endcase
   endfunction

   function automatic logic [1:0] op_len(input cornet_pkg::exec_op_e op);
      case (op)
         cornet_pkg::op_nop, cornet_pkg::op_inx, cornet_pkg::op_dex, cornet_pkg::op_tax,
         cornet_pkg::op_txa, cornet_pkg::op_clc, cornet_pkg::op_sec:
            return `CORNET_LEN_IMPLIED;
         cornet_pkg::op_sta, cornet_pkg::op_jmp, cornet_pkg::op_reset:
            return `CORNET_LEN_ABS;
         default:
            return `CORNET_LEN_IMM;  // Branches always fetch their offset.
      endcase
   endfunction

   assign op_next  = decode_op(fetch_data);
   assign len_next = op_len(op_next);

   always_ff @(posedge clk)
   begin
      fetch_req     <= 1'b0;
      rd_req.strobe <= 1'b0;
      dec_op.start  <= 1'b0;
      if (!reset_n)
      begin
         state <= cornet_pkg::seq_idle;
         pc    <= '0;
      end
      else
      begin
         case (state)
            cornet_pkg::seq_idle:
               state <= cornet_pkg::seq_reset;
            cornet_pkg::seq_reset:
            begin
               rd_req.strobe <= 1'b1;
               rd_req.word   <= 1'b1;
               rd_req.addr   <= `CORNET_RESET_VECTOR;
               dec_op.start  <= 1'b1;
               dec_op.op     <= cornet_pkg::op_reset;
               dec_op.len    <= `CORNET_LEN_ABS;
               dec_op.pc     <= pc;
               state         <= cornet_pkg::seq_wait_exec;
            end
            cornet_pkg::seq_fetch:
            begin
               fetch_req  <= 1'b1;
               fetch_addr <= pc;
               state      <= cornet_pkg::seq_load;
            end
            cornet_pkg::seq_load:
               if (fetch_valid)
               begin
                  dec_op.start  <= 1'b1;
                  dec_op.op     <= op_next;
                  dec_op.len    <= len_next;
                  dec_op.pc     <= pc;
                  rd_req.strobe <= (len_next != `CORNET_LEN_IMPLIED);
                  rd_req.word   <= (len_next == `CORNET_LEN_ABS);
                  rd_req.addr   <= pc + 1'b1;  // Operand follows the opcode.
                  state         <= cornet_pkg::seq_wait_exec;
               end
            cornet_pkg::seq_wait_exec:
               if (exec_rsp.done)
               begin
                  pc    <= exec_rsp.next_pc;
                  state <= cornet_pkg::seq_fetch;
               end
            default:
               state <= cornet_pkg::seq_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- include/cornet_cfg.svh
`ifndef CORNET_CFG_SVH
`define CORNET_CFG_SVH

// Widths of the shared byte bus.
`define CORNET_ADDR_W 16
`define CORNET_DATA_W 8

// The 6502 reset vector, read low byte first.
`define CORNET_RESET_VECTOR 16'hFFFC

// Instruction lengths in bytes, opcode included.
`define CORNET_LEN_IMPLIED 2'd1
`define CORNET_LEN_IMM     2'd2
`define CORNET_LEN_ABS     2'd3

`endif

//--- verif/cornet_cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cornet_cpu_checker (
   input wire                    clk,
   input wire                    reset_n,
   input wire                    rd_req,
   input wire                    wr_en,
   input wire cornet_pkg::addr_t addr
);

   // The shared bus carries one transfer per cycle.
   no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!reset_n)
      !(rd_req && wr_en))
      else $error("rd_req and wr_en are high in the same cycle");

   quiet_after_reset: assert property (@(posedge clk) !reset_n |=> !rd_req && !wr_en)
      else $error("Bus request in the cycle after reset");

   addr_known: assert property (@(posedge clk) disable iff (!reset_n)
      (rd_req || wr_en) |-> !$isunknown(addr))
      else $error("addr is unknown during a bus request");

endmodule

bind cornet_cpu cornet_cpu_checker cornet_cpu_checker_i (
   .clk     (clk),
   .reset_n (reset_n),
   .rd_req  (rd_req),
   .wr_en   (wr_en),
   .addr    (addr)
);

`default_nettype wire

//--- verif/cornet_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cornet_cfg.svh"

module cornet_cpu_tb;

   localparam int clk_period = 4;
   localparam int num_rows   = 12;
   localparam int row_budget = 400;   // Cycles for one program with the longest ready delays.

   localparam cornet_pkg::data_t opc_nop = 8'hEA;
   localparam cornet_pkg::data_t opc_inx = 8'hE8;
   localparam cornet_pkg::data_t opc_dex = 8'hCA;
   localparam cornet_pkg::data_t opc_clc = 8'h18;
   localparam cornet_pkg::data_t opc_sec = 8'h38;
   localparam cornet_pkg::data_t opc_adc = 8'h69;
   localparam cornet_pkg::data_t opc_and = 8'h29;
   localparam cornet_pkg::data_t opc_ora = 8'h09;
   localparam cornet_pkg::data_t opc_cmp = 8'hC9;
   localparam cornet_pkg::data_t opc_beq = 8'hF0;
   localparam cornet_pkg::data_t opc_bne = 8'hD0;

   typedef struct packed {
      cornet_pkg::data_t pre_op;     // Runs between LDX and TXA.
      cornet_pkg::data_t carry_op;
      cornet_pkg::data_t alu_op;
      cornet_pkg::data_t br_op;
      cornet_pkg::data_t a;
      cornet_pkg::data_t b;
      cornet_pkg::data_t exp_acc;
      cornet_pkg::data_t exp_mark;
   } row_t;

   logic              clk;
   logic              reset_n;
   logic              ready;
   logic              wr_en;
   logic              rd_req;
   cornet_pkg::addr_t addr;
   cornet_pkg::data_t rd_data;
   cornet_pkg::data_t wr_data;

   cornet_pkg::data_t mem [0:65535];
   logic              pending;
   logic [1:0]        delay;
   logic [1:0]        delays [256];   // Ready delay for each read in turn.
   logic [7:0]        delay_idx;
   cornet_pkg::addr_t read_addr;
   cornet_pkg::addr_t halt_addr;
   int                halt_hits;
   cornet_pkg::addr_t wr_addr_q [$];
   cornet_pkg::data_t wr_data_q [$];
   row_t              rows [num_rows];

   cornet_cpu cornet_cpu_i (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_addr(input string name, input cornet_pkg::addr_t got,
                             input cornet_pkg::addr_t exp);
      if (got !== exp)
         fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
   endtask

   task automatic check_data(input string name, input cornet_pkg::data_t got,
                             input cornet_pkg::data_t exp);
      if (got !== exp)
         fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
   endtask

   function automatic cornet_pkg::data_t rand_byte();
      return cornet_pkg::data_t'($urandom);
   endfunction

   // Expected store and marker under the 6502 rules for the kept instructions.
   function automatic row_t make_row(input cornet_pkg::data_t pre_op, carry_op, alu_op,
                                     input cornet_pkg::data_t br_op, a, b);
      row_t              r;
      cornet_pkg::data_t acc;
      logic              carry;
      logic              zero;
      int                sum;
      acc = a;
      if (pre_op == opc_inx)
         acc = acc + 8'd1;
      else if (pre_op == opc_dex)
         acc = acc - 8'd1;
      carry = (carry_op == opc_sec);   // Reset leaves the carry clear.
      case (alu_op)
         opc_adc:
         begin
            sum   = int'(acc) + int'(b) + (carry ? 1 : 0);
            acc   = cornet_pkg::data_t'(sum % 256);
            carry = (sum > 255);
         end
         opc_and: acc = acc & b;
         opc_ora: acc = acc | b;
         default: ;
      endcase
      zero = (alu_op == opc_cmp) ? (acc == b) : (acc == 8'd0);
      r.pre_op   = pre_op;
      r.carry_op = carry_op;
      r.alu_op   = alu_op;
      r.br_op    = br_op;
      r.a        = a;
      r.b        = b;
      r.exp_acc  = acc;
      r.exp_mark = {7'd0, (br_op == opc_beq) ? zero : !zero};
      return r;
   endfunction

   task automatic load_program(input row_t r, input cornet_pkg::addr_t start);
      cornet_pkg::addr_t skip_to;
      cornet_pkg::addr_t halt;
      cornet_pkg::data_t prog [25];
      int                i;
      skip_to = start + 16'd19;
      halt    = start + 16'd22;
      prog = '{8'hA2, r.a, r.pre_op, 8'h8A, r.carry_op, r.alu_op, r.b,
               8'h8D, 8'h00, 8'h02, r.br_op, 8'h05, 8'hA9, 8'h00,
               8'h4C, skip_to[7:0], skip_to[15:8], 8'hA9, 8'h01,
               8'h8D, 8'h01, 8'h02, 8'h4C, halt[7:0], halt[15:8]};
      for (i = 0; i < 25; i++)
         mem[cornet_pkg::addr_t'(start + i)] = prog[i];
      mem[`CORNET_RESET_VECTOR]         = start[7:0];
      mem[`CORNET_RESET_VECTOR + 16'd1] = start[15:8];
   endtask

   // Memory answers each read after a random number of cycles with ready low.
   always @(posedge clk)
   begin
      ready <= 1'b0;
      if (wr_en)
         mem[addr] = wr_data;
      if (!reset_n)
         pending <= 1'b0;
      else if (rd_req)
      begin
         pending   <= 1'b1;
         read_addr <= addr;
         delay     <= delays[delay_idx];
         delay_idx <= delay_idx + 8'd1;
      end
      else if (pending)
      begin
         if (delay == 2'd0)
         begin
            ready   <= 1'b1;
            rd_data <= mem[read_addr];
            pending <= 1'b0;
         end
         else
            delay <= delay - 2'd1;
      end
   end

   always @(posedge clk)
   begin
      if (wr_en && rd_req)
         fail_run("A read and a write were on the bus in the same cycle");
      if (wr_en)
      begin
         wr_addr_q.push_back(addr);
         wr_data_q.push_back(wr_data);
      end
      if (rd_req && addr == halt_addr)
         halt_hits++;
   end

   initial
   begin
      #(num_rows * row_budget * clk_period);
      fail_run("Timeout, the programs did not all reach their JMP loop in time");
   end

   initial
   begin
      cornet_pkg::data_t ra;
      cornet_pkg::addr_t start;
      int                seed;
      int                i;
      int                k;
      clk       = 1'b0;
      reset_n  <= 1'b0;
      ready    <= 1'b0;
      rd_data  <= '0;
      halt_addr = '0;
      delay_idx = '0;
      seed      = $urandom(5470);
      for (i = 0; i < 256; i++)
         delays[i] = 2'($urandom_range(3));
      for (i = 0; i < 65536; i++)
         mem[i] = cornet_pkg::data_t'(i ^ (i >> 8) ^ 8'h3C);
      ra = rand_byte();
      rows[0]  = make_row(opc_nop, opc_clc, opc_adc, opc_beq, rand_byte(), rand_byte());
      rows[1]  = make_row(opc_nop, opc_sec, opc_adc, opc_beq, rand_byte(), rand_byte());
      rows[2]  = make_row(opc_nop, opc_sec, opc_adc, opc_bne, 8'hFF, 8'h00);
      rows[3]  = make_row(opc_nop, opc_clc, opc_and, opc_beq, rand_byte(), rand_byte());
      rows[4]  = make_row(opc_nop, opc_nop, opc_ora, opc_bne, rand_byte(), rand_byte());
      rows[5]  = make_row(opc_inx, opc_nop, opc_ora, opc_beq, rand_byte(), 8'h00);
      rows[6]  = make_row(opc_dex, opc_nop, opc_ora, opc_beq, 8'h01, 8'h00);
      rows[7]  = make_row(opc_inx, opc_nop, opc_ora, opc_bne, 8'hFF, 8'h00);
      rows[8]  = make_row(opc_nop, opc_nop, opc_cmp, opc_beq, ra, ra);
      rows[9]  = make_row(opc_nop, opc_nop, opc_cmp, opc_beq, ra, ra + 8'd1);
      rows[10] = make_row(opc_nop, opc_nop, opc_cmp, opc_bne, ra, ra);
      rows[11] = make_row(opc_nop, opc_nop, opc_cmp, opc_bne, ra, ra ^ 8'h80);
      for (k = 0; k < num_rows; k++)
      begin
         start = 16'h8000 + cornet_pkg::addr_t'(k * 64);
         @(posedge clk);
         reset_n <= 1'b0;
         @(negedge clk);
         load_program(rows[k], start);
         halt_addr = start + 16'd22;
         halt_hits = 0;
         wr_addr_q.delete();
         wr_data_q.delete();
         repeat (3) @(posedge clk);
         reset_n <= 1'b1;
         while (wr_addr_q.size() < 2)
            @(negedge clk);
         check_addr($sformatf("row %0d addr of first store", k), wr_addr_q[0], 16'h0200);
         check_data($sformatf("row %0d wr_data of first store", k), wr_data_q[0],
                    rows[k].exp_acc);
         check_addr($sformatf("row %0d addr of marker store", k), wr_addr_q[1], 16'h0201);
         check_data($sformatf("row %0d wr_data of marker", k), wr_data_q[1],
                    rows[k].exp_mark);
         while (halt_hits < 3)
            @(negedge clk);
         if (wr_addr_q.size() != 2)
            fail_run($sformatf("Row %0d wrote again after reaching its JMP loop", k));
      end
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
design/cornet_pkg.sv
design/cornet_sequencer.sv
design/cornet_bus_unit.sv
design/cornet_execute.sv
design/cornet_cpu.sv
verif/cornet_cpu_checker.sv
verif/cornet_cpu_tb.sv
